// ==== verilog/rv_fe_pkg.sv ====
package rv_fe_pkg;

    localparam int XLEN       = 32;               // Data and PC width.
    localparam int IMEM_AW    = 5;                // ROM word-address width.
    localparam int IMEM_DEPTH = 1 << IMEM_AW;     // ROM size in words.

    localparam string IMEM_FILE = "prog.hex";     // ROM image with one word per line.

    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0.

    // RV32I base opcodes handled by decode.
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_ILL
    } instr_fmt_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen through each format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_fmt_t      fmt;
        logic [6:0]      opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [XLEN-1:0] imm;       // Sign-extended. Zero for R and ILL.
        logic            illegal;
    } dec_instr_t;

endpackage

// ==== verilog/imem_rom.sv ====
`timescale 1ns/10ps

module imem_rom (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_fe_pkg::IMEM_AW-1:0] addr_i,
    output logic [rv_fe_pkg::XLEN-1:0]    rdata_o
);
    import rv_fe_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Unlisted words read back as NOP.
    initial begin
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            mem[i] = NOP_WORD;
        end
        $readmemh(IMEM_FILE, mem);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= NOP_WORD;
        end else begin
            rdata_o <= mem[addr_i];        // One-cycle read latency.
        end
    end

endmodule

// ==== verilog/if_stage.sv ====
`timescale 1ns/10ps

module if_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          brj_i,            // Redirect from decode.
    input  logic [rv_fe_pkg::XLEN-1:0]    brj_pc_i,
    input  logic                          stall_i,
    input  logic                          stall_general_i,
    output logic [rv_fe_pkg::IMEM_AW-1:0] instr_addr_o,
    input  logic [rv_fe_pkg::XLEN-1:0]    instr_rdata_i,
    output rv_fe_pkg::instr_u             d_instruction_o,
    output logic [rv_fe_pkg::XLEN-1:0]    d_pc_o,
    output logic [rv_fe_pkg::XLEN-1:0]    d_pc4_o,
    output logic                          d_valid_o
);
    import rv_fe_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;
    logic            stall_any;
    logic            stall_q;          // Previous cycle was stalled.
    logic            slot_valid_q;
    instr_u          hold_instr_q;

    assign stall_any    = stall_i | stall_general_i;
    assign pc4          = pc + XLEN'(4);
    assign instr_addr_o = pc[IMEM_AW+1:2];    // Word index.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!stall_any) begin
            pc <= brj_i ? brj_pc_i : pc4;
        end
    end

    // The slot moves with the ROM read whenever nothing stalls.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_pc_o       <= '0;
            d_pc4_o      <= '0;
            slot_valid_q <= 1'b0;          // First slot after reset is empty.
        end else if (!stall_any) begin
            d_pc_o       <= pc;
            d_pc4_o      <= pc4;
            slot_valid_q <= !brj_i;        // Squash the wrong-path word.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_any;
        end
    end

    // The ROM keeps reading during a stall, so the presented word is kept here.
    always_ff @(posedge clk) begin
        hold_instr_q <= d_instruction_o;
    end

    assign d_instruction_o = stall_q ? hold_instr_q : instr_rdata_i;

    // A stalled slot is not offered to decode.
    assign d_valid_o = slot_valid_q & !stall_any;

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv_fe_pkg::instr_u          d_instruction_i,
    input  logic [rv_fe_pkg::XLEN-1:0] d_pc_i,
    input  logic                       d_valid_i,
    input  logic                       stall_i,
    output logic                       brj_o,          // Valid JAL in this slot.
    output logic [rv_fe_pkg::XLEN-1:0] brj_pc_o,
    output rv_fe_pkg::dec_instr_t      dec_o
);
    import rv_fe_pkg::*;

    logic [6:0]      opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    dec_instr_t      dec_d;

    assign opcode = d_instruction_i.r_fmt.opcode;   // Same place in every format.

    // Immediates per format. The sign bit is always instruction bit 31.
    assign imm_i = {{20{d_instruction_i.i_fmt.imm[11]}}, d_instruction_i.i_fmt.imm};
    assign imm_s = {{20{d_instruction_i.s_fmt.imm_11_5[6]}},
                    d_instruction_i.s_fmt.imm_11_5,
                    d_instruction_i.s_fmt.imm_4_0};
    assign imm_b = {{19{d_instruction_i.b_fmt.imm_12}},
                    d_instruction_i.b_fmt.imm_12,
                    d_instruction_i.b_fmt.imm_11,
                    d_instruction_i.b_fmt.imm_10_5,
                    d_instruction_i.b_fmt.imm_4_1,
                    1'b0};
    assign imm_u = {d_instruction_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{d_instruction_i.j_fmt.imm_20}},
                    d_instruction_i.j_fmt.imm_20,
                    d_instruction_i.j_fmt.imm_19_12,
                    d_instruction_i.j_fmt.imm_11,
                    d_instruction_i.j_fmt.imm_10_1,
                    1'b0};

    // Fields that a format does not define stay zero.
    always_comb begin
        dec_d        = '0;
        dec_d.valid  = d_valid_i;
        dec_d.pc     = d_pc_i;
        dec_d.opcode = opcode;
        case (opcode)
            OP_OP: begin
                dec_d.fmt    = FMT_R;
                dec_d.rd     = d_instruction_i.r_fmt.rd;
                dec_d.rs1    = d_instruction_i.r_fmt.rs1;
                dec_d.rs2    = d_instruction_i.r_fmt.rs2;
                dec_d.funct3 = d_instruction_i.r_fmt.funct3;
                dec_d.funct7 = d_instruction_i.r_fmt.funct7;
            end
            OP_OPIMM, OP_LOAD, OP_JALR: begin
                dec_d.fmt    = FMT_I;
                dec_d.rd     = d_instruction_i.i_fmt.rd;
                dec_d.rs1    = d_instruction_i.i_fmt.rs1;
                dec_d.funct3 = d_instruction_i.i_fmt.funct3;
                dec_d.imm    = imm_i;
            end
            OP_STORE: begin
                dec_d.fmt    = FMT_S;
                dec_d.rs1    = d_instruction_i.s_fmt.rs1;
                dec_d.rs2    = d_instruction_i.s_fmt.rs2;
                dec_d.funct3 = d_instruction_i.s_fmt.funct3;
                dec_d.imm    = imm_s;
            end
            OP_BRANCH: begin
                dec_d.fmt    = FMT_B;     // Not resolved here and falls through.
                dec_d.rs1    = d_instruction_i.b_fmt.rs1;
                dec_d.rs2    = d_instruction_i.b_fmt.rs2;
                dec_d.funct3 = d_instruction_i.b_fmt.funct3;
                dec_d.imm    = imm_b;
            end
            OP_LUI, OP_AUIPC: begin
                dec_d.fmt = FMT_U;
                dec_d.rd  = d_instruction_i.u_fmt.rd;
                dec_d.imm = imm_u;
            end
            OP_JAL: begin
                dec_d.fmt = FMT_J;
                dec_d.rd  = d_instruction_i.j_fmt.rd;
                dec_d.imm = imm_j;
            end
            default: begin
                dec_d.fmt     = FMT_ILL;
                dec_d.illegal = 1'b1;
            end
        endcase
    end

    assign brj_o    = d_valid_i && (opcode == OP_JAL);
    assign brj_pc_o = d_pc_i + imm_j;                  // JAL target.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_o <= '0;
        end else if (stall_i) begin
            dec_o.valid <= 1'b0;           // Contents held.
        end else begin
            dec_o <= dec_d;
        end
    end

endmodule

// ==== verilog/rv_fe_top.sv ====
`timescale 1ns/10ps

module rv_fe_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_i,
    input  logic                  stall_general_i,
    output rv_fe_pkg::dec_instr_t dec_o
);
    import rv_fe_pkg::*;

    logic [IMEM_AW-1:0] instr_addr;
    logic [XLEN-1:0]    instr_rdata;
    instr_u             d_instruction;
    logic [XLEN-1:0]    d_pc;
    logic               d_valid;
    logic               brj;
    logic [XLEN-1:0]    brj_pc;

    imem_rom u_imem (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_i  (instr_addr),
        .rdata_o (instr_rdata)
    );

    // The link address pc+4 has no consumer in this front end.
    if_stage u_if (
        .clk             (clk),
        .rst_n           (rst_n),
        .brj_i           (brj),
        .brj_pc_i        (brj_pc),
        .stall_i         (stall_i),
        .stall_general_i (stall_general_i),
        .instr_addr_o    (instr_addr),
        .instr_rdata_i   (instr_rdata),
        .d_instruction_o (d_instruction),
        .d_pc_o          (d_pc),
        .d_pc4_o         (),
        .d_valid_o       (d_valid)
    );

    id_stage u_id (
        .clk             (clk),
        .rst_n           (rst_n),
        .d_instruction_i (d_instruction),
        .d_pc_i          (d_pc),
        .d_valid_i       (d_valid),
        .stall_i         (stall_i),
        .brj_o           (brj),
        .brj_pc_o        (brj_pc),
        .dec_o           (dec_o)
    );

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
    parameter realtime HALF_PERIOD = 4ns,
    parameter int      RST_CYCLES  = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;      // 8 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                             // Released away from the active edge.
    end

endmodule

// ==== bench/rv_fe_chk.sv ====
`timescale 1ns/10ps

module rv_fe_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       stall_i,
    input logic                       brj_i,
    input logic [rv_fe_pkg::XLEN-1:0] brj_pc_i,
    input rv_fe_pkg::dec_instr_t      dec_i
);
    import rv_fe_pkg::*;

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!dec_i.valid && !brj_i))
        else $error("decoded output or redirect active during reset");

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        brj_i |-> (brj_pc_i[1:0] == 2'b00))
        else $error("JAL target is not word aligned");

    // Decode register drops valid one cycle after a stall.
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !dec_i.valid)
        else $error("decoded output valid right after a stall");

    a_jal_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (dec_i.valid && (dec_i.opcode == OP_JAL)) |=> !dec_i.valid)
        else $error("JAL output not followed by a bubble");

endmodule

bind id_stage rv_fe_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_i  (stall_i),
    .brj_i    (brj_o),
    .brj_pc_i (brj_pc_o),
    .dec_i    (dec_o)
);

// ==== bench/tb_rv_fe.sv ====
`timescale 1ns/10ps

module tb_rv_fe;
    import rv_fe_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int SELF_REPEATS   = 3;      // Extra passes through the final self loop.

    logic            clk;
    logic            rst_n;
    logic            stall_i;
    logic            stall_general_i;
    dec_instr_t      dec_o;
    logic [XLEN-1:0] prog [IMEM_DEPTH];
    dec_instr_t      exp_q [$];
    logic [31:0]     lcg_state;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_fe_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (stall_i),
        .stall_general_i (stall_general_i),
        .dec_o           (dec_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected decode of one word from the RV32I bit layout.
    function automatic dec_instr_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
        dec_instr_t d;
        d        = '0;
        d.valid  = 1'b1;
        d.pc     = pc;
        d.opcode = w[6:0];
        case (w[6:0])
            OP_OP: begin
                d.fmt    = FMT_R;
                d.rd     = w[11:7];
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.funct7 = w[31:25];
            end
            OP_OPIMM, OP_LOAD, OP_JALR: begin
                d.fmt    = FMT_I;
                d.rd     = w[11:7];
                d.rs1    = w[19:15];
                d.funct3 = w[14:12];
                d.imm    = {{20{w[31]}}, w[31:20]};
            end
            OP_STORE: begin
                d.fmt    = FMT_S;
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BRANCH: begin
                d.fmt    = FMT_B;
                d.rs1    = w[19:15];
                d.rs2    = w[24:20];
                d.funct3 = w[14:12];
                d.imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                d.fmt = FMT_U;
                d.rd  = w[11:7];
                d.imm = {w[31:12], 12'b0};
            end
            OP_JAL: begin
                d.fmt = FMT_J;
                d.rd  = w[11:7];
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                d.fmt     = FMT_ILL;
                d.illegal = 1'b1;
            end
        endcase
        return d;
    endfunction

    // Walks the program from pc 0 and follows each JAL. Branches fall through.
    function automatic void build_expected();
        logic [31:0] pc;
        dec_instr_t  d;
        int          self_hits;
        int          steps;
        pc        = '0;
        self_hits = 0;
        steps     = 0;
        while (self_hits <= SELF_REPEATS && steps < 100) begin
            d = ref_decode(prog[pc[IMEM_AW+1:2]], pc);
            exp_q.push_back(d);
            steps++;
            if (d.opcode == OP_JAL) begin
                if (d.imm == '0) begin
                    self_hits++;
                end
                pc = pc + d.imm;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endfunction

    task automatic check_pc(input dec_instr_t got, input dec_instr_t exp);
        if (got.pc !== exp.pc) begin
            $display("ERROR dec_o.pc got %h expected %h", got.pc, exp.pc);
            $display("tests failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_dec(input dec_instr_t got, input dec_instr_t exp);
        if (got !== exp) begin
            $display("ERROR dec_o got %h expected %h", got, exp);
            $display("tests failed");
            $fatal(1, "decoded instruction mismatch");
        end
    endtask

    // Random stalls on both flags at about one cycle in eight each.
    initial begin
        stall_i         = 1'b0;
        stall_general_i = 1'b0;
        lcg_state       = 32'h1027;
        forever begin
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            stall_i         <= (lcg_state[15:13] == 3'd0);
            stall_general_i <= (lcg_state[20:18] == 3'd0);
        end
    end

    initial begin
        int wait_cycles;
        $readmemh("bench/prog.hex", prog);
        build_expected();
        wait_cycles = 0;
        while (!rst_n && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!rst_n) begin
            $display("Reset was never released.");
            $display("tests failed");
            $fatal(1, "reset timeout");
        end
        for (int idx = 0; idx < exp_q.size(); idx++) begin
            wait_cycles = 0;
            do begin
                @(negedge clk);                     // Outputs are stable here.
                wait_cycles++;
            end while (!dec_o.valid && wait_cycles < TIMEOUT_CYCLES);
            if (!dec_o.valid) begin
                $display("No decoded instruction arrived within %0d cycles (entry %0d).",
                         TIMEOUT_CYCLES, idx);
                $display("tests failed");
                $fatal(1, "output timeout");
            end
            check_pc(dec_o, exp_q[idx]);
            check_dec(dec_o, exp_q[idx]);
        end
        repeat (4) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== bench/prog.hex ====
// One RV32I instruction word per line, word address 0 upward.
// Ends with a JAL to itself at 0x50.
FFF00093
002081B3
404182B3
FF812303
FE712E23
FE208CE3
12345437
FFFFF497
00C000EF
7FF00F93
00000013
FFFFFFFF
0F05F513
00D61863
0100006F
0107E733
0100006F
7FF00F93
011902A3
FF1FF0EF
0000006F
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013

// ==== compile.f ====
verilog/rv_fe_pkg.sv
verilog/imem_rom.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/rv_fe_top.sv
bench/tb_clkgen.sv
bench/rv_fe_chk.sv
bench/tb_rv_fe.sv

// ==== Makefile ====
# Verilator build and run of the RV32I front end testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv_fe
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
PROG      ?= bench/prog.hex
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The ROM image is read by name from the run directory.
prog.hex: $(PROG)
	cp $(PROG) prog.hex

test: $(SIM) prog.hex
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR) prog.hex
